/* sim.f */
rtl/mc_addr_pkg.sv
rtl/mc_net_pkg.sv
rtl/dram_hash_function.sv
rtl/eva_to_npa.sv
rtl/wb_remote_req.sv
rtl/mc_remote_xlate_top.sv
verification/mc_remote_xlate_assert.sv
verification/tb_mc_remote_xlate.sv

/* Makefile */
# Verilator build and run of the remote address translator testbench

VERILATOR ?= verilator
TOP       ?= tb_mc_remote_xlate
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_mc_remote_xlate.sv */
// testbench for the remote address translator, table requests then random dram requests
`timescale 1ns/1ns

module tb_mc_remote_xlate;
  import mc_net_pkg::*;

  localparam int clk_period = 40;
  localparam int timeout_cycles = 64;
  localparam int num_vec = 10;
  localparam int num_rand = 32;
  localparam logic [2:0] pod_x_fix = 3'd2;
  localparam logic [3:0] pod_y_fix = 4'd5;

  typedef struct packed {
    logic [31:0] eva;
    logic        we;
    logic [31:0] data;
    logic [3:0]  sel;
    logic [3:0]  stall;
    logic        is_err;
    logic [6:0]  x;
    logic [6:0]  y;
    logic [27:0] epa;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic [2:0]  pod_x;
  logic [3:0]  pod_y;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic [3:0]  wb_sel;
  logic        wb_ack;
  logic        wb_err;
  logic        net_v;
  logic        net_ready;
  logic [6:0]  net_x;
  logic [6:0]  net_y;
  logic [27:0] net_epa;
  logic [1:0]  net_op;
  logic [31:0] net_data;
  logic [3:0]  net_mask;

  int seed;
  int error_count;
  int check_count;

  // eva, we, data, sel, stall, is_err, x, y, epa
  vec_t vec_tbl [num_vec] = '{
    '{32'h4935_48D0, 1'b1, 32'hDEAD_BEEF, 4'hF, 4'd0, 1'b0, 7'h35, 7'h12, 28'h000_1234},
    '{32'h7F81_FFFC, 1'b0, 32'h0000_0000, 4'h0, 4'd3, 1'b0, 7'h01, 7'h7F, 28'h000_3FFF},
    '{32'h4040_0003, 1'b1, 32'h0000_A5A5, 4'h3, 4'd5, 1'b0, 7'h40, 7'h00, 28'h000_0000},
    '{32'h0000_1000, 1'b1, 32'h1234_5678, 4'hF, 4'd0, 1'b1, 7'h00, 7'h00, 28'h000_0000},
    '{32'h8000_0000, 1'b0, 32'h0000_0000, 4'h0, 4'd0, 1'b0, 7'h20, 7'h27, 28'h000_0000},
    '{32'h8000_0274, 1'b1, 32'hCAFE_F00D, 4'hC, 4'd2, 1'b0, 7'h23, 7'h30, 28'h000_0005},
    '{32'h8000_0400, 1'b0, 32'h0000_0000, 4'h0, 4'd0, 1'b0, 7'h25, 7'h27, 28'h000_0008},
    '{32'h8000_1000, 1'b1, 32'h0BAD_CAFE, 4'h1, 4'd1, 1'b0, 7'h24, 7'h30, 28'h000_0020},
    '{32'h3FFF_FFFC, 1'b0, 32'h0000_0000, 4'h0, 4'd0, 1'b1, 7'h00, 7'h00, 28'h000_0000},
    '{32'hC000_0000, 1'b0, 32'h0000_0000, 4'h0, 4'd0, 1'b0, 7'h20, 7'h27, 28'h080_0000}
  };

  mc_remote_xlate_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .pod_x_i     (pod_x),
    .pod_y_i     (pod_y),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat),
    .wb_sel_i    (wb_sel),
    .wb_ack_o    (wb_ack),
    .wb_err_o    (wb_err),
    .net_v_o     (net_v),
    .net_ready_i (net_ready),
    .net_x_o     (net_x),
    .net_y_o     (net_y),
    .net_epa_o   (net_epa),
    .net_op_o    (net_op),
    .net_data_o  (net_data),
    .net_mask_o  (net_mask)
  );

  bind mc_remote_xlate_top mc_remote_xlate_assert u_assert (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ack_i       (wb_ack_o),
    .err_i       (wb_err_o),
    .net_v_i     (net_v_o),
    .net_ready_i (net_ready_i),
    .pkt_i       ({net_x_o, net_y_o, net_epa_o, net_op_o, net_data_o, net_mask_o})
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ipoly reference, returns {x, y, epa}
  function automatic logic [41:0] hash_ref(input logic [31:0] eva);
    logic [20:0] idx;
    logic [3:0]  col;
    logic        south;
    logic [3:0]  row_pod;
    idx = eva[30:10];
    col = eva[8:5];
    col[0] = col[0] ^ (^(idx & 21'h03E69));
    col[1] = col[1] ^ (^(idx & 21'h07CD2));
    col[2] = col[2] ^ (^(idx & 21'h047CD));
    col[3] = col[3] ^ (^(idx & 21'h00F9A));
    south = eva[9] ^ (^(idx & 21'h01F34));
    row_pod = south ? pod_y_fix + 4'd1 : pod_y_fix - 4'd1;
    return {pod_x_fix, col, row_pod, south ? 3'b000 : 3'b111, 4'b0000, idx, eva[4:2]};
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_packet(input vec_t v);
    compare_field("net_x_o", 32'(net_x), 32'(v.x));
    compare_field("net_y_o", 32'(net_y), 32'(v.y));
    compare_field("net_epa_o", 32'(net_epa), 32'(v.epa));
    compare_field("net_op_o", 32'(net_op), 32'(v.we ? op_store : op_load));
    compare_field("net_data_o", net_data, v.data);
    compare_field("net_mask_o", 32'(net_mask), 32'(v.sel));
  endtask

  // one wishbone request, entered and left just after a falling edge
  task automatic run_request(input vec_t v);
    int   cycles;
    int   stall_left;
    int   xfers;
    int   stalls;
    logic done;
    logic got_ack;
    logic got_err;
    cycles = 0;
    xfers = 0;
    stalls = 0;
    done = 1'b0;
    got_ack = 1'b0;
    got_err = 1'b0;
    stall_left = int'(v.stall);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = v.we;
    wb_adr = v.eva;
    wb_dat = v.data;
    wb_sel = v.sel;
    net_ready = 1'b0;
    while (!done && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      if (wb_ack || wb_err) begin
        done = 1'b1;
        got_ack = wb_ack;
        got_err = wb_err;
      end else if (net_v) begin
        if (v.is_err) begin
          error_count++;
          $display("net_v_o went high for local EVA 0x%h", v.eva);
        end
        check_packet(v);
        // ready for the coming rising edge
        if (stall_left > 0) begin
          net_ready = 1'b0;
          stall_left--;
          stalls++;
        end else begin
          net_ready = 1'b1;
          xfers++;
        end
      end
    end
    if (!done) begin
      error_count++;
      $display("timeout waiting for ack or err on EVA 0x%h", v.eva);
    end else begin
      compare_field("wb_ack_o", 32'(got_ack), 32'(!v.is_err));
      compare_field("wb_err_o", 32'(got_err), 32'(v.is_err));
      compare_field("latency", 32'(cycles), v.is_err ? 32'd2 : 32'd2 + 32'(v.stall));
      compare_field("packet count", 32'(xfers), v.is_err ? 32'd0 : 32'd1);
      compare_field("stall cycles", 32'(stalls), v.is_err ? 32'd0 : 32'(v.stall));
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    net_ready = 1'b0;
    @(negedge clk);
    // responses are single-cycle pulses
    compare_field("wb_ack_o", 32'(wb_ack), 32'd0);
    compare_field("wb_err_o", 32'(wb_err), 32'd0);
    compare_field("net_v_o", 32'(net_v), 32'd0);
  endtask

  initial begin
    vec_t        rv;
    logic [31:0] rnd;
    int          i;
    seed = 83201;
    error_count = 0;
    check_count = 0;
    rst_n = 1'b0;
    pod_x = pod_x_fix;
    pod_y = pod_y_fix;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 32'h0;
    wb_dat = 32'h0;
    wb_sel = 4'h0;
    net_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_field("net_v_o", 32'(net_v), 32'd0);
    compare_field("wb_ack_o", 32'(wb_ack), 32'd0);
    compare_field("wb_err_o", 32'(wb_err), 32'd0);
    for (i = 0; i < num_vec; i++) begin
      run_request(vec_tbl[i]);
    end
    for (i = 0; i < num_rand; i++) begin
      rnd = $random(seed);
      rv.eva = {1'b1, rnd[30:0]};
      rnd = $random(seed);
      rv.data = $random(seed);
      rv.we = rnd[0];
      rv.sel = rnd[7:4];
      rv.stall = {2'b00, rnd[9:8]};
      rv.is_err = 1'b0;
      {rv.x, rv.y, rv.epa} = hash_ref(rv.eva);
      run_request(rv);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verification/mc_remote_xlate_assert.sv */
// protocol checks on the wishbone and injection sides of the translator
`timescale 1ns/1ns

module mc_remote_xlate_assert (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        ack_i,
  input logic        err_i,
  input logic        net_v_i,
  input logic        net_ready_i,
  input logic [79:0] pkt_i
);

  // a request ends with exactly one kind of response
  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_i && err_i))
    else $error("wb_ack_o and wb_err_o high in the same cycle");

  // stalled packet keeps valid and every field
  pkt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (net_v_i && !net_ready_i) |=> (net_v_i && $stable(pkt_i)))
    else $error("net packet changed or dropped while net_ready_i was low");

  v_low_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !net_v_i)
    else $error("net_v_o high during reset");

endmodule

/* rtl/mc_remote_xlate_top.sv */
// remote address translator of one tile, from core wishbone to mesh injection
`timescale 1ns/1ns

module mc_remote_xlate_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [mc_addr_pkg::pod_x_w-1:0]   pod_x_i,
  input  logic [mc_addr_pkg::pod_y_w-1:0]   pod_y_i,

  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [mc_addr_pkg::eva_w-1:0]     wb_adr_i,
  input  logic [mc_net_pkg::data_w-1:0]     wb_dat_i,
  input  logic [mc_net_pkg::mask_w-1:0]     wb_sel_i,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,

  output logic                              net_v_o,
  input  logic                              net_ready_i,
  output logic [mc_net_pkg::x_cord_w-1:0]   net_x_o,
  output logic [mc_net_pkg::y_cord_w-1:0]   net_y_o,
  output logic [mc_net_pkg::epa_w-1:0]      net_epa_o,
  output logic [mc_net_pkg::op_w-1:0]       net_op_o,
  output logic [mc_net_pkg::data_w-1:0]     net_data_o,
  output logic [mc_net_pkg::mask_w-1:0]     net_mask_o
);

  mc_addr_pkg::eva_u                 eva;
  logic                              is_remote;
  logic [mc_net_pkg::x_cord_w-1:0]   x_cord;
  logic [mc_net_pkg::y_cord_w-1:0]   y_cord;
  logic [mc_net_pkg::epa_w-1:0]      epa;

  wb_remote_req u_req (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .eva_o       (eva),
    .is_remote_i (is_remote),
    .x_cord_i    (x_cord),
    .y_cord_i    (y_cord),
    .epa_i       (epa),
    .net_v_o     (net_v_o),
    .net_ready_i (net_ready_i),
    .net_x_o     (net_x_o),
    .net_y_o     (net_y_o),
    .net_epa_o   (net_epa_o),
    .net_op_o    (net_op_o),
    .net_data_o  (net_data_o),
    .net_mask_o  (net_mask_o)
  );

  // zero-latency translation of the held address
  eva_to_npa u_xlate (
    .eva_i       (eva),
    .pod_x_i     (pod_x_i),
    .pod_y_i     (pod_y_i),
    .is_remote_o (is_remote),
    .x_cord_o    (x_cord),
    .y_cord_o    (y_cord),
    .epa_o       (epa)
  );

endmodule

/* rtl/wb_remote_req.sv */
// wishbone classic slave that turns one core access into one injected packet
`timescale 1ns/1ns

module wb_remote_req (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [mc_addr_pkg::eva_w-1:0]     wb_adr_i,
  input  logic [mc_net_pkg::data_w-1:0]     wb_dat_i,
  input  logic [mc_net_pkg::mask_w-1:0]     wb_sel_i,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,

  output mc_addr_pkg::eva_u                 eva_o,
  input  logic                              is_remote_i,
  input  logic [mc_net_pkg::x_cord_w-1:0]   x_cord_i,
  input  logic [mc_net_pkg::y_cord_w-1:0]   y_cord_i,
  input  logic [mc_net_pkg::epa_w-1:0]      epa_i,

  output logic                              net_v_o,
  input  logic                              net_ready_i,
  output logic [mc_net_pkg::x_cord_w-1:0]   net_x_o,
  output logic [mc_net_pkg::y_cord_w-1:0]   net_y_o,
  output logic [mc_net_pkg::epa_w-1:0]      net_epa_o,
  output logic [mc_net_pkg::op_w-1:0]       net_op_o,
  output logic [mc_net_pkg::data_w-1:0]     net_data_o,
  output logic [mc_net_pkg::mask_w-1:0]     net_mask_o
);
  import mc_net_pkg::*;

  logic [st_w-1:0] state_q;
  logic            req;
  logic            accept;

  // master holds the address for the whole request
  assign eva_o = wb_adr_i;

  assign req    = wb_cyc_i & wb_stb_i;
  assign accept = (state_q == st_idle) & req;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= st_idle;
      net_v_o  <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept) begin
            if (is_remote_i) begin
              net_v_o <= 1'b1;
              state_q <= st_send;
            end else begin
              state_q <= st_resp;
            end
          end
        end
        st_send: begin
          // ack goes out the cycle after the handshake
          if (net_ready_i) begin
            net_v_o  <= 1'b0;
            wb_ack_o <= 1'b1;
            state_q  <= st_resp;
          end
        end
        st_resp: begin
          // a local access arrives here with nothing pulsed yet
          if (wb_ack_o | wb_err_o) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            state_q  <= st_idle;
          end else begin
            wb_err_o <= 1'b1;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // packet fields loaded once per remote request, held until the transfer
  always_ff @(posedge clk_i) begin
    if (accept && is_remote_i) begin
      net_x_o    <= x_cord_i;
      net_y_o    <= y_cord_i;
      net_epa_o  <= epa_i;
      net_op_o   <= wb_we_i ? op_store : op_load;
      net_data_o <= wb_dat_i;
      net_mask_o <= wb_sel_i;
    end
  end

endmodule

/* rtl/eva_to_npa.sv */
// classifies a core EVA and picks the network address for dram or global space
`timescale 1ns/1ns

module eva_to_npa (
  input  mc_addr_pkg::eva_u                eva_i,
  input  logic [mc_addr_pkg::pod_x_w-1:0]  pod_x_i,
  input  logic [mc_addr_pkg::pod_y_w-1:0]  pod_y_i,
  output logic                             is_remote_o,
  output logic [mc_net_pkg::x_cord_w-1:0]  x_cord_o,
  output logic [mc_net_pkg::y_cord_w-1:0]  y_cord_o,
  output logic [mc_net_pkg::epa_w-1:0]     epa_o
);
  import mc_addr_pkg::*;
  import mc_net_pkg::*;

  logic                is_dram;
  logic                is_global;
  logic [x_cord_w-1:0] dram_x;
  logic [y_cord_w-1:0] dram_y;
  logic [epa_w-1:0]    dram_epa;
  logic [epa_w-1:0]    glob_epa;

  dram_hash_function u_hash (
    .eva_i    (eva_i),
    .pod_x_i  (pod_x_i),
    .pod_y_i  (pod_y_i),
    .x_cord_o (dram_x),
    .y_cord_o (dram_y),
    .epa_o    (dram_epa)
  );

  assign is_dram   = eva_i.dram.space;
  assign is_global = (eva_i.glob.space == space_global);

  // local space never leaves the tile
  assign is_remote_o = is_dram | is_global;

  assign glob_epa = {{(epa_w - glob_word_w){1'b0}}, eva_i.glob.word};

  always_comb begin
    if (is_dram) begin
      x_cord_o = dram_x;
      y_cord_o = dram_y;
      epa_o    = dram_epa;
    end else begin
      // tile named directly by the address
      x_cord_o = eva_i.glob.x;
      y_cord_o = eva_i.glob.y;
      epa_o    = glob_epa;
    end
  end

endmodule

/* rtl/dram_hash_function.sv */
// ipoly hash of a dram EVA onto the north or south vcache row of the pod
`timescale 1ns/1ns

module dram_hash_function (
  input  mc_addr_pkg::eva_u                    eva_i,
  input  logic [mc_addr_pkg::pod_x_w-1:0]      pod_x_i,
  input  logic [mc_addr_pkg::pod_y_w-1:0]      pod_y_i,
  output logic [mc_net_pkg::x_cord_w-1:0]      x_cord_o,
  output logic [mc_net_pkg::y_cord_w-1:0]      y_cord_o,
  output logic [mc_net_pkg::epa_w-1:0]         epa_o
);
  import mc_addr_pkg::*;
  import mc_net_pkg::*;

  logic [dram_index_w-1:0] idx;
  logic [x_subcord_w-1:0]  x_sub;
  logic [x_subcord_w-1:0]  x_hash;
  logic                    is_south;
  logic [pod_y_w-1:0]      dram_pod_y;
  logic [y_subcord_w-1:0]  dram_y_sub;

  assign idx   = eva_i.dram.index;
  assign x_sub = eva_i.dram.x_subcord;

  // each output column bit folds in a fixed set of index bits
  if (x_subcord_w == 4) begin : g_hash4
    assign x_hash[0] = x_sub[0] ^ idx[0] ^ idx[3] ^ idx[5] ^ idx[6] ^ idx[9]
                     ^ idx[10] ^ idx[11] ^ idx[12] ^ idx[13];
    assign x_hash[1] = x_sub[1] ^ idx[1] ^ idx[4] ^ idx[6] ^ idx[7] ^ idx[10]
                     ^ idx[11] ^ idx[12] ^ idx[13] ^ idx[14];
    assign x_hash[2] = x_sub[2] ^ idx[0] ^ idx[2] ^ idx[3] ^ idx[6] ^ idx[7]
                     ^ idx[8] ^ idx[9] ^ idx[10] ^ idx[14];
    assign x_hash[3] = x_sub[3] ^ idx[1] ^ idx[3] ^ idx[4] ^ idx[7] ^ idx[8]
                     ^ idx[9] ^ idx[10] ^ idx[11];
    assign is_south  = eva_i.dram.row_id[0] ^ idx[2] ^ idx[4] ^ idx[5] ^ idx[8]
                     ^ idx[9] ^ idx[10] ^ idx[11] ^ idx[12];
  end else if (x_subcord_w == 5) begin : g_hash5
    assign x_hash[0] = x_sub[0] ^ idx[0] ^ idx[5] ^ idx[6] ^ idx[10] ^ idx[12]
                     ^ idx[15] ^ idx[16] ^ idx[17] ^ idx[18];
    assign x_hash[1] = x_sub[1] ^ idx[0] ^ idx[1] ^ idx[5] ^ idx[7] ^ idx[10]
                     ^ idx[11] ^ idx[12] ^ idx[13] ^ idx[15];
    assign x_hash[2] = x_sub[2] ^ idx[1] ^ idx[2] ^ idx[6] ^ idx[8] ^ idx[11]
                     ^ idx[12] ^ idx[13] ^ idx[14] ^ idx[16];
    assign x_hash[3] = x_sub[3] ^ idx[2] ^ idx[3] ^ idx[7] ^ idx[9] ^ idx[12]
                     ^ idx[13] ^ idx[14] ^ idx[15] ^ idx[17];
    assign x_hash[4] = x_sub[4] ^ idx[3] ^ idx[4] ^ idx[8] ^ idx[10] ^ idx[13]
                     ^ idx[14] ^ idx[15] ^ idx[16] ^ idx[18];
    assign is_south  = eva_i.dram.row_id[0] ^ idx[4] ^ idx[5] ^ idx[9] ^ idx[11]
                     ^ idx[14] ^ idx[15] ^ idx[16] ^ idx[17];
  end else begin : g_hash_bad
    $error("ipoly hash supports only 4 or 5 vcache columns");
  end

  // vcache rows sit in the pods just above and below this one
  assign dram_pod_y = is_south ? pod_y_w'(pod_y_i + 1'b1) : pod_y_w'(pod_y_i - 1'b1);

  // north row is the bottom subrow of its pod, south row the top one
  assign dram_y_sub = {y_subcord_w{~is_south}};

  assign x_cord_o = {pod_x_i, x_hash};
  assign y_cord_o = {dram_pod_y, dram_y_sub};
  assign epa_o    = {{(epa_w - dram_index_w - word_off_w){1'b0}}, idx, eva_i.dram.word_off};

endmodule

/* rtl/mc_net_pkg.sv */
// mesh injection packet widths, opcodes and request FSM encoding
package mc_net_pkg;

  // destination coordinates, pod part on top of the subcord
  localparam int x_cord_w = mc_addr_pkg::pod_x_w + mc_addr_pkg::x_subcord_w;
  localparam int y_cord_w = mc_addr_pkg::pod_y_w + mc_addr_pkg::y_subcord_w;

  // word address at the destination
  localparam int epa_w = 28;

  localparam int data_w = 32;
  localparam int mask_w = data_w / 8;

  localparam int op_w = 2;
  localparam logic [op_w-1:0] op_load = 2'd0;
  localparam logic [op_w-1:0] op_store = 2'd1;

  // request slave states
  localparam int st_w = 2;
  localparam logic [st_w-1:0] st_idle = 2'd0;
  localparam logic [st_w-1:0] st_send = 2'd1;
  localparam logic [st_w-1:0] st_resp = 2'd2;

endpackage

/* rtl/mc_addr_pkg.sv */
// address map of the tile remote port, with the two decodings of a core EVA
package mc_addr_pkg;

  localparam int eva_w = 32;
  localparam int byte_w = 2;

  // pod geometry
  localparam int x_subcord_w = 4;
  localparam int pod_x_w = 3;
  localparam int pod_y_w = 4;
  localparam int y_subcord_w = 3;

  // vcache line layout
  localparam int vcache_block_words = 8;
  localparam int word_off_w = $clog2(vcache_block_words);
  localparam int row_id_w = 1;

  // whatever is left above the line, column and row bits
  localparam int dram_index_w = eva_w - 1 - byte_w - word_off_w - x_subcord_w - row_id_w;

  // global space fields
  localparam int glob_y_w = pod_y_w + y_subcord_w;
  localparam int glob_x_w = pod_x_w + x_subcord_w;
  localparam int glob_word_w = eva_w - 2 - glob_y_w - glob_x_w - byte_w;

  // bits 31:30 of a global EVA; bit 31 alone marks dram
  localparam logic [1:0] space_global = 2'b01;

  typedef union packed {
    struct packed {
      logic                    space;
      logic [dram_index_w-1:0] index;
      logic [row_id_w-1:0]     row_id;
      logic [x_subcord_w-1:0]  x_subcord;
      logic [word_off_w-1:0]   word_off;
      logic [byte_w-1:0]       byte_off;
    } dram;
    struct packed {
      logic [1:0]             space;
      logic [glob_y_w-1:0]    y;
      logic [glob_x_w-1:0]    x;
      logic [glob_word_w-1:0] word;
      logic [byte_w-1:0]      byte_off;
    } glob;
  } eva_u;

endpackage
